/* logic/cheat_pkg.sv */
package cheat_pkg;

	// One cheat record, flags in the top word as in the download layout
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// Flag bit that makes the patch depend on the original data
	localparam int flag_use_compare = 0;

	// Byte offsets of the half-words within a 16-byte record
	localparam logic [3:0] off_flags_lo = 4'd0;
	localparam logic [3:0] off_flags_hi = 4'd2;
	localparam logic [3:0] off_addr_lo  = 4'd4;
	localparam logic [3:0] off_addr_hi  = 4'd6;
	localparam logic [3:0] off_cmp_lo   = 4'd8;
	localparam logic [3:0] off_cmp_hi   = 4'd10;
	localparam logic [3:0] off_repl_lo  = 4'd12;
	localparam logic [3:0] off_repl_hi  = 4'd14;

	localparam int default_num_slots = 4;

	// Width of an index into n slots, never below one bit
	function automatic int slot_idx_w(int n);
		return (n > 1) ? $clog2(n) : 1;
	endfunction

endpackage

/* logic/rom_bus_pkg.sv */
package rom_bus_pkg;

	// ROM is read as 16-bit words
	localparam int rom_addr_w = 24;
	localparam int rom_data_w = 16;

	typedef logic [rom_addr_w-1:0] rom_addr_t;
	typedef logic [rom_data_w-1:0] rom_data_t;

	// Download side uses byte addresses
	localparam int dl_addr_w = 25;

	typedef logic [dl_addr_w-1:0] dl_addr_t;

endpackage

/* logic/cheat_load_if.sv */
interface cheat_load_if #(
	parameter int num_slots = cheat_pkg::default_num_slots
);

	// Record commit towards one slot
	logic                                         commit;
	logic [cheat_pkg::slot_idx_w(num_slots)-1:0] slot_idx;
	cheat_pkg::cheat_code_t                       code;

	// Empties every slot
	logic                                         clear;

	modport loader (output commit, slot_idx, code, clear);
	modport slot (input commit, slot_idx, code, clear);

endinterface

/* logic/rom_word_if.sv */
interface rom_word_if;

	logic                   valid;
	logic                   ready;
	rom_bus_pkg::rom_addr_t addr;
	rom_bus_pkg::rom_data_t data;

	// Producer side
	modport src (output valid, addr, data, input ready);

	// Consumer side
	modport dst (input valid, addr, data, output ready);

	// Observers that only look at the staged word
	modport mon (input valid, ready, addr, data);

endinterface

/* logic/cheat_code_loader.sv */
module cheat_code_loader #(
	parameter int num_slots = cheat_pkg::default_num_slots
) (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   dl_wr,
	input  rom_bus_pkg::dl_addr_t  dl_addr,
	input  rom_bus_pkg::rom_data_t dl_data,
	cheat_load_if.loader           load,
	output logic                   codes_available
);

	localparam int idx_w = cheat_pkg::slot_idx_w(num_slots);
	// Counter must also hold the full value num_slots
	localparam int cnt_w = cheat_pkg::slot_idx_w(num_slots + 1);
	localparam logic [cnt_w-1:0] cnt_max = cnt_w'(num_slots);

	cheat_pkg::cheat_code_t asm_q;
	logic [cnt_w-1:0]       count_q;
	logic [3:0]             offset;
	logic                   has_room;

	assign offset   = dl_addr[3:0];
	assign has_room = count_q < cnt_max;

	//////////////////////////////////////////////////
	// Record assembly

	always_ff @(posedge clk_sys) begin
		if (dl_wr) begin
			case (offset)
				cheat_pkg::off_flags_lo: asm_q.flags[15:0]    <= dl_data;
				cheat_pkg::off_flags_hi: asm_q.flags[31:16]   <= dl_data;
				cheat_pkg::off_addr_lo:  asm_q.address[15:0]  <= dl_data;
				cheat_pkg::off_addr_hi:  asm_q.address[31:16] <= dl_data;
				cheat_pkg::off_cmp_lo:   asm_q.compare[15:0]  <= dl_data;
				cheat_pkg::off_cmp_hi:   asm_q.compare[31:16] <= dl_data;
				cheat_pkg::off_repl_lo:  asm_q.replace[15:0]  <= dl_data;
				cheat_pkg::off_repl_hi:  asm_q.replace[31:16] <= dl_data;
				default: ;
			endcase
		end
	end

	// Last half-word bypasses the register so the commit lands on this edge
	always_comb begin
		load.code = asm_q;
		load.code.replace[31:16] = dl_data;
	end

	//////////////////////////////////////////////////
	// Slot allocation

	assign load.clear    = dl_wr && (dl_addr == '0);
	assign load.commit   = dl_wr && (offset == cheat_pkg::off_repl_hi) && has_room;
	assign load.slot_idx = count_q[idx_w-1:0];

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			count_q <= '0;
		end else if (load.clear) begin
			count_q <= '0;
		end else if (load.commit) begin
			count_q <= count_q + 1'b1;
		end
	end

	// Slots fill in order, so a nonzero count means at least one is occupied
	assign codes_available = (count_q != '0);

	a_commit_in_range: assert property (@(posedge clk_sys) disable iff (!arst_n)
		load.commit |-> (load.slot_idx < num_slots));

endmodule

/* logic/rom_read_tap.sv */
module rom_read_tap (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   rd_valid,
	input  rom_bus_pkg::rom_addr_t rd_addr,
	input  rom_bus_pkg::rom_data_t rd_data,
	output logic                   rd_ready,
	rom_word_if.src                staged
);

	logic                   valid_q;
	rom_bus_pkg::rom_addr_t addr_q;
	rom_bus_pkg::rom_data_t data_q;

	// Free, or draining into the merge stage this cycle
	assign rd_ready = !valid_q || staged.ready;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
		end else if (rd_ready) begin
			valid_q <= rd_valid;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rd_valid && rd_ready) begin
			addr_q <= rd_addr;
			data_q <= rd_data;
		end
	end

	// Staged word, seen by every slot and by the merge
	assign staged.valid = valid_q;
	assign staged.addr  = addr_q;
	assign staged.data  = data_q;

	a_staged_hold: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(staged.valid && !staged.ready) |=>
			(staged.valid && $stable(staged.addr) && $stable(staged.data)));

endmodule

/* logic/cheat_slot.sv */
module cheat_slot #(
	parameter int slot_index = 0
) (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   cheats_en,
	cheat_load_if.slot             load,
	rom_word_if.mon                staged,
	output logic                   hit,
	output rom_bus_pkg::rom_data_t replace
);

	cheat_pkg::cheat_code_t code_q;
	logic                   used_q;
	logic                   addr_match;
	logic                   data_match;
	logic                   use_cmp;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			used_q <= 1'b0;
		end else if (load.clear) begin
			used_q <= 1'b0;
		end else if (load.commit && (int'(load.slot_idx) == slot_index)) begin
			used_q <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (load.commit && (int'(load.slot_idx) == slot_index)) begin
			code_q <= load.code;
		end
	end

	//////////////////////////////////////////////////
	// Match against the staged word

	assign addr_match = code_q.address[rom_bus_pkg::rom_addr_w-1:0] == staged.addr;
	assign data_match = code_q.compare[rom_bus_pkg::rom_data_w-1:0] == staged.data;
	assign use_cmp    = code_q.flags[cheat_pkg::flag_use_compare];

	assign hit     = used_q && cheats_en && addr_match && (!use_cmp || data_match);
	assign replace = code_q.replace[rom_bus_pkg::rom_data_w-1:0];

endmodule

/* logic/patch_merge.sv */
module patch_merge #(
	parameter int num_slots = cheat_pkg::default_num_slots
) (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	rom_word_if.dst                staged,
	input  logic [num_slots-1:0]   hits,
	input  rom_bus_pkg::rom_data_t replaces [num_slots],
	output logic                   out_valid,
	input  logic                   out_ready,
	output rom_bus_pkg::rom_addr_t out_addr,
	output rom_bus_pkg::rom_data_t out_data
);

	localparam int idx_w = cheat_pkg::slot_idx_w(num_slots);

	logic [idx_w-1:0]       win_idx;
	logic                   hit_any;
	rom_bus_pkg::rom_data_t patched;

	//////////////////////////////////////////////////
	// Priority select, lowest slot wins

	always_comb begin
		win_idx = '0;
		for (int i = num_slots - 1; i >= 0; i--) begin
			if (hits[i]) begin
				win_idx = idx_w'(i);
			end
		end
	end

	assign hit_any = |hits;
	assign patched = hit_any ? replaces[win_idx] : staged.data;

	//////////////////////////////////////////////////
	// Output register

	assign staged.ready = !out_valid || out_ready;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else if (staged.ready) begin
			out_valid <= staged.valid;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (staged.valid && staged.ready) begin
			out_addr <= staged.addr;
			out_data <= patched;
		end
	end

	a_out_hold: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(out_valid && !out_ready) |=>
			(out_valid && $stable(out_data) && $stable(out_addr)));

endmodule

/* logic/cheat_patcher_top.sv */
module cheat_patcher_top #(
	parameter int num_slots = cheat_pkg::default_num_slots
) (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   cheats_en,

	// Code download
	input  logic                   dl_wr,
	input  rom_bus_pkg::dl_addr_t  dl_addr,
	input  rom_bus_pkg::rom_data_t dl_data,

	// ROM read stream in
	input  logic                   rd_valid,
	output logic                   rd_ready,
	input  rom_bus_pkg::rom_addr_t rd_addr,
	input  rom_bus_pkg::rom_data_t rd_data,

	// Patched stream out
	output logic                   out_valid,
	input  logic                   out_ready,
	output rom_bus_pkg::rom_addr_t out_addr,
	output rom_bus_pkg::rom_data_t out_data,

	output logic                   codes_available
);

	logic [num_slots-1:0]   slot_hit;
	rom_bus_pkg::rom_data_t slot_repl [num_slots];

	cheat_load_if #(.num_slots(num_slots)) load_bus ();
	rom_word_if staged ();

	cheat_code_loader #(.num_slots(num_slots)) i_loader (
		.clk_sys         (clk_sys),
		.arst_n          (arst_n),
		.dl_wr           (dl_wr),
		.dl_addr         (dl_addr),
		.dl_data         (dl_data),
		.load            (load_bus.loader),
		.codes_available (codes_available)
	);

	rom_read_tap i_tap (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.rd_valid (rd_valid),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.rd_ready (rd_ready),
		.staged   (staged.src)
	);

	//////////////////////////////////////////////////
	// Slot bank

	for (genvar g = 0; g < num_slots; g++) begin : g_slot
		cheat_slot #(.slot_index(g)) i_slot (
			.clk_sys   (clk_sys),
			.arst_n    (arst_n),
			.cheats_en (cheats_en),
			.load      (load_bus.slot),
			.staged    (staged.mon),
			.hit       (slot_hit[g]),
			.replace   (slot_repl[g])
		);
	end

	patch_merge #(.num_slots(num_slots)) i_merge (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.staged    (staged.dst),
		.hits      (slot_hit),
		.replaces  (slot_repl),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_addr  (out_addr),
		.out_data  (out_data)
	);

endmodule

/* tb/tb_cheat_model.svh */
`ifndef TB_CHEAT_MODEL_SVH
`define TB_CHEAT_MODEL_SVH

// Codes the DUT should hold, in slot order
cheat_pkg::cheat_code_t tbl [num_slots];
int                     tbl_count = 0;

// Galois LFSR state, x^32 + x^22 + x^2 + x + 1
logic [31:0] lfsr_state = 32'he7b92154;

function automatic void table_clear();
	tbl_count = 0;
endfunction

// Codes past the last slot are dropped
function automatic void table_add(input cheat_pkg::cheat_code_t c);
	if (tbl_count < num_slots) begin
		tbl[tbl_count] = c;
		tbl_count++;
	end
endfunction

// Expected data of one read word, lowest matching code wins
function automatic rom_bus_pkg::rom_data_t expected_data(
	input rom_bus_pkg::rom_addr_t a,
	input rom_bus_pkg::rom_data_t d,
	input logic                   en
);
	logic use_cmp;
	for (int i = 0; i < tbl_count; i++) begin
		use_cmp = tbl[i].flags[0];
		if (en && tbl[i].address[23:0] == a && (!use_cmp || tbl[i].compare[15:0] == d)) begin
			return tbl[i].replace[15:0];
		end
	end
	return d;
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		r[i] = lfsr_state[0];
		lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
	end
	return r;
endfunction

`endif

/* tb/tb_cheat_patcher.sv */
module tb_cheat_patcher;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int num_slots = 4;

	logic                   clk_sys;
	logic                   arst_n;
	logic                   cheats_en;
	logic                   dl_wr;
	rom_bus_pkg::dl_addr_t  dl_addr;
	rom_bus_pkg::rom_data_t dl_data;
	logic                   rd_valid;
	logic                   rd_ready;
	rom_bus_pkg::rom_addr_t rd_addr;
	rom_bus_pkg::rom_data_t rd_data;
	logic                   out_valid;
	logic                   out_ready;
	rom_bus_pkg::rom_addr_t out_addr;
	rom_bus_pkg::rom_data_t out_data;
	logic                   codes_available;

	// Expected words in arrival order
	rom_bus_pkg::rom_addr_t exp_addr_q [$];
	rom_bus_pkg::rom_data_t exp_data_q [$];

	int   errors = 0;
	int   checks = 0;
	int   test_no = 0;
	int   test_err = 0;
	int   test_chk = 0;
	logic random_ready = 1'b0;

	`include "tb_cheat_model.svh"

	cheat_patcher_top #(.num_slots(num_slots)) i_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////
	// Helpers

	task automatic abort_run(input string what);
		$display("Timeout while waiting for %s at %0t ns", what, $time);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		assert (actual === expected) else begin
			$display("Error: %0t ns %s is %b, expected %b", $time, name, actual, expected);
			errors++;
		end
	endtask

	function automatic cheat_pkg::cheat_code_t make_code(
		input logic                   use_cmp,
		input rom_bus_pkg::rom_addr_t a,
		input rom_bus_pkg::rom_data_t cmp,
		input rom_bus_pkg::rom_data_t repl
	);
		cheat_pkg::cheat_code_t c;
		// Upper bits are junk that the patch rule must ignore
		c.flags   = 32'(use_cmp) << cheat_pkg::flag_use_compare;
		c.address = {8'hc3, a};
		c.compare = {16'h7e00, cmp};
		c.replace = {16'hffff, repl};
		return c;
	endfunction

	// Called and returning at a rising edge plus 5 ns
	task automatic dl_write(input rom_bus_pkg::dl_addr_t a, input rom_bus_pkg::rom_data_t d);
		dl_wr = 1'b1;
		dl_addr = a;
		dl_data = d;
		if (a == '0) begin
			table_clear();
		end
		@(posedge clk_sys);
		#5;
		dl_wr = 1'b0;
	endtask

	task automatic load_record(input int rec, input cheat_pkg::cheat_code_t c);
		rom_bus_pkg::dl_addr_t base;
		base = rom_bus_pkg::dl_addr_t'(rec * 16);
		dl_write(base + cheat_pkg::off_flags_lo, c.flags[15:0]);
		dl_write(base + cheat_pkg::off_flags_hi, c.flags[31:16]);
		dl_write(base + cheat_pkg::off_addr_lo, c.address[15:0]);
		dl_write(base + cheat_pkg::off_addr_hi, c.address[31:16]);
		dl_write(base + cheat_pkg::off_cmp_lo, c.compare[15:0]);
		dl_write(base + cheat_pkg::off_cmp_hi, c.compare[31:16]);
		dl_write(base + cheat_pkg::off_repl_lo, c.replace[15:0]);
		dl_write(base + cheat_pkg::off_repl_hi, c.replace[31:16]);
		table_add(c);
	endtask

	task automatic send_word(input rom_bus_pkg::rom_addr_t a, input rom_bus_pkg::rom_data_t d);
		int waited;
		rd_valid = 1'b1;
		rd_addr = a;
		rd_data = d;
		waited = 0;
		@(negedge clk_sys);
		while (!rd_ready) begin
			waited++;
			if (waited > 200) begin
				abort_run("rd_ready");
			end
			@(negedge clk_sys);
		end
		// Accepted at the coming edge
		exp_addr_q.push_back(a);
		exp_data_q.push_back(expected_data(a, d, cheats_en));
		@(posedge clk_sys);
		#5;
		rd_valid = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_addr_q.size() != 0 || out_valid) begin
			waited++;
			if (waited > 1000) begin
				abort_run("the output stream to drain");
			end
			@(posedge clk_sys);
			#5;
		end
	endtask

	task automatic end_test(input string name);
		test_no++;
		$display("Test %0d %s: %0d words checked, %0d errors", test_no, name,
			checks - test_chk, errors - test_err);
		test_chk = checks;
		test_err = errors;
	endtask

	//////////////////////////////////////////////////
	// Output comparison

	initial begin
		rom_bus_pkg::rom_addr_t exp_a;
		rom_bus_pkg::rom_data_t exp_d;
		forever begin
			@(negedge clk_sys);
			if (out_valid === 1'b1 && out_ready === 1'b1) begin
				assert (exp_addr_q.size() != 0) else begin
					$display("Output word at address %h arrived with nothing expected", out_addr);
					errors++;
				end
				if (exp_addr_q.size() != 0) begin
					exp_a = exp_addr_q.pop_front();
					exp_d = exp_data_q.pop_front();
					checks++;
					assert (out_addr === exp_a && out_data === exp_d) else begin
						$display("Error: %0t ns addr %h data %h, expected addr %h data %h",
							$time, out_addr, out_data, exp_a, exp_d);
						errors++;
					end
				end
			end
		end
	end

	// Random back-pressure only while enabled
	initial begin
		forever begin
			@(posedge clk_sys);
			#3;
			out_ready = random_ready ? 1'(rand_bits(1)) : 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Tests

	initial begin
		rom_bus_pkg::rom_addr_t rnd_addr;
		rom_bus_pkg::rom_data_t rnd_data;
		arst_n = 1'b0;
		cheats_en = 1'b1;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		rd_valid = 1'b0;
		rd_addr = '0;
		rd_data = '0;
		out_ready = 1'b1;
		repeat (2) @(posedge clk_sys);
		#5;
		arst_n = 1'b1;

		check_bit("out_valid", out_valid, 1'b0);
		check_bit("rd_ready", rd_ready, 1'b1);
		for (int i = 0; i < 20; i++) begin
			rnd_addr = rom_bus_pkg::rom_addr_t'(rand_bits(24));
			rnd_data = rom_bus_pkg::rom_data_t'(rand_bits(16));
			send_word(rnd_addr, rnd_data);
		end
		wait_drain();
		check_bit("codes_available", codes_available, 1'b0);
		end_test("no codes");

		load_record(0, make_code(1'b0, 24'h001230, 16'h0000, 16'hbeef));
		check_bit("codes_available", codes_available, 1'b1);
		for (int i = -1; i <= 1; i++) begin
			rnd_data = rom_bus_pkg::rom_data_t'(rand_bits(16));
			send_word(rom_bus_pkg::rom_addr_t'(24'h001230 + i), rnd_data);
		end
		wait_drain();
		end_test("unconditional code");

		load_record(0, make_code(1'b1, 24'h00abc0, 16'h5a5a, 16'h1234));
		send_word(24'h00abc0, 16'h5a5a);
		send_word(24'h00abc0, 16'h5a5b);
		send_word(24'h00abc2, 16'h5a5a);
		wait_drain();
		end_test("compare code");

		load_record(0, make_code(1'b0, 24'h07f000, 16'h0000, 16'h1111));
		load_record(1, make_code(1'b0, 24'h07f000, 16'h0000, 16'h2222));
		cheats_en = 1'b0;
		send_word(24'h07f000, 16'h0042);
		send_word(24'h07f000, 16'h0043);
		wait_drain();
		cheats_en = 1'b1;
		send_word(24'h07f000, 16'h0044);
		wait_drain();
		end_test("enable and priority");

		for (int k = 0; k < 5; k++) begin
			load_record(k, make_code(1'b0, rom_bus_pkg::rom_addr_t'(24'h000200 + k), 16'h0000,
				rom_bus_pkg::rom_data_t'(16'h5000 + k)));
		end
		check_bit("codes_available", codes_available, 1'b1);
		for (int k = 0; k < 5; k++) begin
			send_word(rom_bus_pkg::rom_addr_t'(24'h000200 + k), 16'h0000);
		end
		wait_drain();
		// A lone write at address zero empties the bank
		dl_write('0, 16'h0000);
		check_bit("codes_available", codes_available, 1'b0);
		for (int k = 0; k < 5; k++) begin
			send_word(rom_bus_pkg::rom_addr_t'(24'h000200 + k), 16'h0000);
		end
		wait_drain();
		end_test("overflow and clear");

		load_record(0, make_code(1'b0, 24'h000104, 16'h0000, 16'hc0de));
		load_record(1, make_code(1'b1, 24'h000106, 16'h00a1, 16'hd00d));
		load_record(2, make_code(1'b0, 24'h000104, 16'h0000, 16'heeee));
		load_record(3, make_code(1'b1, 24'h000109, 16'h00a2, 16'hf00f));
		random_ready = 1'b1;
		for (int i = 0; i < 200; i++) begin
			if (rand_bits(2) == 0) begin
				repeat (1 + rand_bits(2)) @(posedge clk_sys);
				#5;
			end
			rnd_addr = rom_bus_pkg::rom_addr_t'(24'h000100 + rand_bits(4));
			rnd_data = rom_bus_pkg::rom_data_t'(16'h00a0 + rand_bits(2));
			send_word(rnd_addr, rnd_data);
		end
		wait_drain();
		random_ready = 1'b0;
		end_test("random stream");

		$display("Summary: %0d tests, %0d words checked, %0d errors", test_no, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* cheat_patcher.f */
+incdir+tb
logic/cheat_pkg.sv
logic/rom_bus_pkg.sv
logic/cheat_load_if.sv
logic/rom_word_if.sv
logic/cheat_code_loader.sv
logic/rom_read_tap.sv
logic/cheat_slot.sv
logic/patch_merge.sv
logic/cheat_patcher_top.sv
tb/tb_cheat_patcher.sv
